//--- flist.f
common/audioPkg.sv
clkRst/clkRstGen.sv
audio/sampleFifo.sv
audio/pwmModulator.sv
audio/audioCfgRegs.sv
src/audioTop.sv
sim/audioTb.sv

//--- run.sh
#!/bin/sh
# Build and run the audio playback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module audioTb \
    -f flist.f \
    -o audioSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/audioSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- sim/audioTb.sv
// Audio playback testbench
module audioTb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                              wAudioClk = 1'b0;
    logic                              rstN;
    logic                              pllLocked;
    logic                              sampleValid;
    logic [audioPkg::sampleWidth-1:0]  sampleData;
    logic                              creditReturn;
    logic                              cfgWrEn;
    logic [audioPkg::cfgAddrWidth-1:0] cfgAddr;
    logic [audioPkg::cfgDataWidth-1:0] cfgWrData;
    logic [audioPkg::cfgDataWidth-1:0] cfgRdData;
    logic                              pwmOut;
    logic                              frameSync;

    // Model of the FIFO contents and the sender's credits
    logic [audioPkg::sampleWidth-1:0] model [$];
    logic [audioPkg::sampleWidth-1:0] pendData;
    logic        pendValid = 1'b0;
    logic [15:0] lfsrState = 16'd3;
    int credits = audioPkg::fifoDepth;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    int framesSeen = 0;
    // Register values the model assumes
    int volSet = 0;
    int divSet = 0;
    // Frame measurement
    bit measuring = 1'b0;
    bit popNow;
    int cycleCnt;
    int highCnt;
    int expHigh;
    int frameLen;

    always #50 wAudioClk = ~wAudioClk;

    audioTop audioTop_inst (
        .wAudioClk    (wAudioClk),
        .rstN         (rstN),
        .pllLocked    (pllLocked),
        .sampleValid  (sampleValid),
        .sampleData   (sampleData),
        .creditReturn (creditReturn),
        .cfgWrEn      (cfgWrEn),
        .cfgAddr      (cfgAddr),
        .cfgWrData    (cfgWrData),
        .cfgRdData    (cfgRdData),
        .pwmOut       (pwmOut),
        .frameSync    (frameSync)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic expectEqual(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected)
        else
        begin
            errors++;
            $display("FAIL %0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        if (s[0])
            lfsrNext = (s >> 1) ^ 16'hB400;
        else
            lfsrNext = s >> 1;
    endfunction

    // One LFSR step per sample bit
    function automatic logic [audioPkg::sampleWidth-1:0] drawSample();
        logic [audioPkg::sampleWidth-1:0] v;
        int i;
        v = '0;
        for (i = 0; i < audioPkg::sampleWidth; i++)
        begin
            v = {v[audioPkg::sampleWidth-2:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    // Floor of sample over 2^(vol+8), then offset to mid scale
    function automatic int dutyFor(input logic [audioPkg::sampleWidth-1:0] s, input int vol);
        int v;
        int d;
        int q;
        v = int'($signed(s));
        d = 1 << (vol + 8);
        q = v / d;
        // Division truncates, the shift rounds down
        if ((v < 0) && (q * d != v))
            q = q - 1;
        return q + int'(audioPkg::dutyMid);
    endfunction

    // --------------------------------------------------
    // Output monitor and FIFO model
    // --------------------------------------------------
    // Values seen here are the ones before the edge
    always @(posedge wAudioClk)
    begin
        popNow = frameSync && (model.size() != 0);
        if (frameSync)
        begin
            // Close the previous frame
            if (measuring)
            begin
                expectEqual("frameSync period", frameLen, cycleCnt);
                expectEqual("pwmOut high count", expHigh, highCnt);
            end
            if (popNow)
                expHigh = dutyFor(model.pop_front(), volSet) * (divSet + 1);
            else
                expHigh = int'(audioPkg::dutyMid) * (divSet + 1);
            frameLen = 256 * (divSet + 1);
            cycleCnt = 0;
            highCnt = 0;
            measuring = 1'b1;
            framesSeen++;
        end
        // Credit comes one cycle after the pop, same cycle as frameSync
        expectEqual("creditReturn", int'(popNow), int'(creditReturn));
        // Write of the last cycle lands after this frame's pop decision
        if (pendValid && (model.size() < audioPkg::fifoDepth))
            model.push_back(pendData);
        pendValid = sampleValid;
        pendData = sampleData;
        if (creditReturn)
            credits++;
        assert (credits <= audioPkg::fifoDepth)
        else
        begin
            errors++;
            $display("FAIL %0t credits went above the FIFO depth (%0d)", $time, credits);
        end
        if (measuring)
        begin
            cycleCnt++;
            highCnt += int'(pwmOut);
        end
    end

    assert property (@(posedge wAudioClk) !pllLocked |=> !frameSync && !creditReturn && !pwmOut)
    else
    begin
        errors++;
        $display("FAIL %0t audio outputs active while the PLL is not locked", $time);
    end

    assert property (@(posedge wAudioClk) frameSync |=> !frameSync)
    else
    begin
        errors++;
        $display("FAIL %0t frameSync lasted more than one cycle", $time);
    end

    // --------------------------------------------------
    // Bus and stimulus tasks, all start and end on a falling edge
    // --------------------------------------------------
    task automatic writeReg(input logic [1:0] addr, input logic [7:0] data);
        cfgWrEn = 1'b1;
        cfgAddr = addr;
        cfgWrData = data;
        @(negedge wAudioClk);
        cfgWrEn = 1'b0;
    endtask

    task automatic readExpect(input logic [1:0] addr, input int expected, input string name);
        cfgAddr = addr;
        @(posedge wAudioClk);
        expectEqual(name, expected, int'(cfgRdData));
        @(negedge wAudioClk);
    endtask

    task automatic checkQuiet(input logic [1:0] addr);
        cfgAddr = addr;
        @(posedge wAudioClk);
        expectEqual("pwmOut", 0, int'(pwmOut));
        expectEqual("frameSync", 0, int'(frameSync));
        expectEqual("creditReturn", 0, int'(creditReturn));
        expectEqual("cfgRdData", 0, int'(cfgRdData));
        @(negedge wAudioClk);
    endtask

    task automatic setEnable(input bit on);
        writeReg(audioPkg::regCtrl, {7'd0, on});
        if (!on)
        begin
            // A frame may still start on the write edge
            repeat (2) @(negedge wAudioClk);
            measuring = 1'b0;
        end
    endtask

    // Spends one credit, waits for one if none is left
    task automatic sendSample(input logic [audioPkg::sampleWidth-1:0] value);
        int waited;
        waited = 0;
        while ((credits == 0) && (waited < 2000))
        begin
            @(negedge wAudioClk);
            waited++;
        end
        if (credits == 0)
        begin
            timeouts++;
            $display("Timeout at %0t: no credit came back within 2000 cycles", $time);
        end
        else
        begin
            sampleValid = 1'b1;
            sampleData = value;
            credits--;
            @(negedge wAudioClk);
            sampleValid = 1'b0;
        end
    endtask

    task automatic sendSamples(input int n);
        int i;
        for (i = 0; i < n; i++)
            sendSample(drawSample());
    endtask

    // Back to back writes with no regard for credits
    task automatic sendBurst(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            sampleValid = 1'b1;
            sampleData = drawSample();
            @(negedge wAudioClk);
        end
        sampleValid = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (((model.size() != 0) || pendValid) && (waited < 20000))
        begin
            @(negedge wAudioClk);
            waited++;
        end
        if ((model.size() != 0) || pendValid)
        begin
            timeouts++;
            $display("Timeout at %0t: FIFO did not drain", $time);
        end
    endtask

    task automatic waitFrames(input int n);
        int target;
        int waited;
        target = framesSeen + n;
        waited = 0;
        while ((framesSeen < target) && (waited < n * 1000))
        begin
            @(negedge wAudioClk);
            waited++;
        end
        if (framesSeen < target)
        begin
            timeouts++;
            $display("Timeout at %0t: frame pulses stopped coming", $time);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial
    begin
        int a;
        rstN = 1'b0;
        pllLocked = 1'b0;
        sampleValid = 1'b0;
        sampleData = '0;
        cfgWrEn = 1'b0;
        cfgAddr = '0;
        cfgWrData = '0;
        // Two reset cycles
        checkQuiet(audioPkg::regCtrl);
        checkQuiet(audioPkg::regVolume);
        rstN = 1'b1;
        // Board reset gone, lock still missing
        for (a = 0; a < 4; a++)
            checkQuiet(2'(a));
        pllLocked = 1'b1;
        repeat (3) @(negedge wAudioClk);

        // Duty at full scale, sender limited by credits
        setEnable(1'b1);
        readExpect(audioPkg::regCtrl, 1, "ctrl readback");
        sendSamples(12);
        waitDrain();
        waitFrames(2);

        // Volume shift, loaded while idle
        setEnable(1'b0);
        writeReg(audioPkg::regVolume, 8'd3);
        volSet = 3;
        readExpect(audioPkg::regVolume, 3, "volume readback");
        sendSamples(6);
        setEnable(1'b1);
        waitDrain();
        // Empty FIFO plays silence
        waitFrames(3);
        readExpect(audioPkg::regStatus, 2, "status underflow");

        // Overflow with the modulator stopped
        setEnable(1'b0);
        writeReg(audioPkg::regStatus, 8'h03);
        readExpect(audioPkg::regStatus, 0, "status cleared");
        sendBurst(audioPkg::fifoDepth + 1);
        // Every credit is spent, the dropped sample's credit is gone
        credits = 0;
        repeat (3) @(negedge wAudioClk);
        readExpect(audioPkg::regStatus, 1, "status overflow");
        writeReg(audioPkg::regStatus, 8'h01);
        readExpect(audioPkg::regStatus, 0, "status after clear");
        setEnable(1'b1);
        waitDrain();
        waitFrames(2);
        expectEqual("credits returned", audioPkg::fifoDepth, credits);

        // Slower ticks stretch the frame
        setEnable(1'b0);
        writeReg(audioPkg::regTickDiv, 8'd2);
        divSet = 2;
        readExpect(audioPkg::regTickDiv, 2, "tickDiv readback");
        sendSamples(3);
        setEnable(1'b1);
        waitDrain();
        waitFrames(2);

        // Lock loss resets the audio domain
        pllLocked = 1'b0;
        @(negedge wAudioClk);
        repeat (800)
        begin
            @(posedge wAudioClk);
            expectEqual("frameSync", 0, int'(frameSync));
        end
        @(negedge wAudioClk);
        readExpect(audioPkg::regCtrl, 0, "ctrl after lock loss");

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- src/audioTop.sv
// Audio playback top level
module audioTop (
    input  logic                              wAudioClk,
    input  logic                              rstN,
    input  logic                              pllLocked,
    input  logic                              sampleValid,
    input  logic [audioPkg::sampleWidth-1:0]  sampleData,
    output logic                              creditReturn,
    input  logic                              cfgWrEn,
    input  logic [audioPkg::cfgAddrWidth-1:0] cfgAddr,
    input  logic [audioPkg::cfgDataWidth-1:0] cfgWrData,
    output logic [audioPkg::cfgDataWidth-1:0] cfgRdData,
    output logic                              pwmOut,
    output logic                              frameSync
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    logic                             audioRstN;
    logic                             pwmTick;
    logic [audioPkg::divWidth-1:0]    tickDiv;
    logic                             enable;
    logic [audioPkg::volWidth-1:0]    volume;
    logic [audioPkg::sampleWidth-1:0] headData;
    logic                             sampleAvail;
    logic                             pop;
    logic                             overflow;
    logic                             underflow;

    // Reset release and frame pacing
    clkRstGen clkRstGen_inst (
        .wAudioClk (wAudioClk),
        .rstN      (rstN),
        .pllLocked (pllLocked),
        .tickDiv   (tickDiv),
        .audioRstN (audioRstN),
        .pwmTick   (pwmTick)
    );

    // Control and sticky status
    audioCfgRegs audioCfgRegs_inst (
        .wAudioClk (wAudioClk),
        .audioRstN (audioRstN),
        .cfgWrEn   (cfgWrEn),
        .cfgAddr   (cfgAddr),
        .cfgWrData (cfgWrData),
        .cfgRdData (cfgRdData),
        .overflow  (overflow),
        .underflow (underflow),
        .enable    (enable),
        .volume    (volume),
        .tickDiv   (tickDiv)
    );

    // Credit-controlled sample buffer
    sampleFifo sampleFifo_inst (
        .wAudioClk    (wAudioClk),
        .audioRstN    (audioRstN),
        .sampleValid  (sampleValid),
        .sampleData   (sampleData),
        .pop          (pop),
        .headData     (headData),
        .sampleAvail  (sampleAvail),
        .creditReturn (creditReturn),
        .overflow     (overflow)
    );

    // Pin driver
    pwmModulator pwmModulator_inst (
        .wAudioClk   (wAudioClk),
        .audioRstN   (audioRstN),
        .pwmTick     (pwmTick),
        .enable      (enable),
        .volume      (volume),
        .headData    (headData),
        .sampleAvail (sampleAvail),
        .pop         (pop),
        .underflow   (underflow),
        .frameSync   (frameSync),
        .pwmOut      (pwmOut)
    );

endmodule

//--- audio/audioCfgRegs.sv
// Audio configuration registers
module audioCfgRegs (
    input  logic                              wAudioClk,
    input  logic                              audioRstN,
    input  logic                              cfgWrEn,
    input  logic [audioPkg::cfgAddrWidth-1:0] cfgAddr,
    input  logic [audioPkg::cfgDataWidth-1:0] cfgWrData,
    output logic [audioPkg::cfgDataWidth-1:0] cfgRdData,
    input  logic                              overflow,
    input  logic                              underflow,
    output logic                              enable,
    output logic [audioPkg::volWidth-1:0]     volume,
    output logic [audioPkg::divWidth-1:0]     tickDiv
);

    // Sticky event flags
    logic ovfFlag;
    logic udfFlag;
    logic statusWr;

    assign statusWr = cfgWrEn & (cfgAddr == audioPkg::regStatus);

    // --------------------------------------------------
    // Steering registers
    // --------------------------------------------------
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            enable  <= 1'b0;
            volume  <= '0;
            tickDiv <= '0;
        end
        else if (cfgWrEn)
        begin
            case (cfgAddr)
                audioPkg::regCtrl:    enable  <= cfgWrData[0];
                audioPkg::regVolume:  volume  <= cfgWrData[audioPkg::volWidth-1:0];
                audioPkg::regTickDiv: tickDiv <= cfgWrData[audioPkg::divWidth-1:0];
                default:              ;
            endcase
        end
    end

    // --------------------------------------------------
    // Status, set beats clear
    // --------------------------------------------------
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            ovfFlag <= 1'b0;
            udfFlag <= 1'b0;
        end
        else
        begin
            ovfFlag <= overflow  | (ovfFlag & ~(statusWr & cfgWrData[0]));
            udfFlag <= underflow | (udfFlag & ~(statusWr & cfgWrData[1]));
        end
    end

    // Readback mux, unused bits read 0
    always_comb
    begin
        cfgRdData = '0;
        case (cfgAddr)
            audioPkg::regCtrl:    cfgRdData[0] = enable;
            audioPkg::regVolume:  cfgRdData[audioPkg::volWidth-1:0] = volume;
            audioPkg::regTickDiv: cfgRdData[audioPkg::divWidth-1:0] = tickDiv;
            default:              cfgRdData[1:0] = {udfFlag, ovfFlag};
        endcase
    end

endmodule

//--- audio/pwmModulator.sv
// PWM audio modulator
module pwmModulator (
    input  logic                             wAudioClk,
    input  logic                             audioRstN,
    input  logic                             pwmTick,
    input  logic                             enable,
    input  logic [audioPkg::volWidth-1:0]    volume,
    input  logic [audioPkg::sampleWidth-1:0] headData,
    input  logic                             sampleAvail,
    output logic                             pop,
    output logic                             underflow,
    output logic                             frameSync,
    output logic                             pwmOut
);

    // Tick position inside the current frame
    logic [audioPkg::dutyWidth-1:0] frameCnt;
    // Duty latched for the current frame
    logic [audioPkg::dutyWidth-1:0] duty;
    logic [audioPkg::dutyWidth-1:0] newDuty;
    logic signed [audioPkg::sampleWidth-1:0] scaled;
    logic frameStart;

    // --------------------------------------------------
    // Frame boundary and sample fetch
    // --------------------------------------------------
    assign frameStart = enable & pwmTick & (frameCnt == '0);
    // Take the head if there is one
    assign pop        = frameStart & sampleAvail;
    // Otherwise report a starved frame
    assign underflow  = frameStart & ~sampleAvail;

    // Volume as an arithmetic right shift
    assign scaled = $signed(headData) >>> volume;

    // Top byte of the scaled sample, offset to mid scale
    // Wraps modulo 256, empty FIFO plays silence
    assign newDuty = sampleAvail
                   ? scaled[audioPkg::sampleWidth-1 -: audioPkg::dutyWidth] + audioPkg::dutyMid
                   : audioPkg::dutyMid;

    // --------------------------------------------------
    // Counter, duty and pin
    // --------------------------------------------------
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            frameCnt  <= '0;
            duty      <= '0;
            frameSync <= 1'b0;
            pwmOut    <= 1'b0;
        end
        else if (!enable)
        begin
            // Idle, next enable starts a fresh frame
            frameCnt  <= '0;
            frameSync <= 1'b0;
            pwmOut    <= 1'b0;
        end
        else
        begin
            frameSync <= frameStart;
            if (pwmTick)
            begin
                frameCnt <= frameCnt + 1'b1;
                if (frameCnt == '0)
                begin
                    // First tick already uses the new duty
                    duty   <= newDuty;
                    pwmOut <= (newDuty != '0);
                end
                else
                begin
                    pwmOut <= (frameCnt < duty);
                end
            end
        end
    end

endmodule

//--- audio/sampleFifo.sv
// Credit-returning sample FIFO
module sampleFifo (
    input  logic                             wAudioClk,
    input  logic                             audioRstN,
    input  logic                             sampleValid,
    input  logic [audioPkg::sampleWidth-1:0] sampleData,
    input  logic                             pop,
    output logic [audioPkg::sampleWidth-1:0] headData,
    output logic                             sampleAvail,
    output logic                             creditReturn,
    output logic                             overflow
);

    // Sample storage
    logic [audioPkg::sampleWidth-1:0] mem [audioPkg::fifoDepth];
    logic [audioPkg::fifoAddrWidth-1:0] wrPtr;
    logic [audioPkg::fifoAddrWidth-1:0] rdPtr;
    // One extra bit so a full buffer is countable
    logic [audioPkg::fifoAddrWidth:0] count;
    logic full;
    logic wrAccept;
    logic popAccept;

    // --------------------------------------------------
    // Status and handshakes
    // --------------------------------------------------
    assign full        = (count == (audioPkg::fifoAddrWidth + 1)'(audioPkg::fifoDepth));
    assign sampleAvail = (count != '0);
    // Writes into a full buffer are lost
    assign wrAccept    = sampleValid & ~full;
    // Popping an empty buffer does nothing
    assign popAccept   = pop & sampleAvail;
    // Show-ahead head, no read latency
    assign headData    = mem[rdPtr];

    // Storage only, no reset needed
    always_ff @(posedge wAudioClk)
    begin
        if (wrAccept)
        begin
            mem[wrPtr] <= sampleData;
        end
    end

    // --------------------------------------------------
    // Pointers, count, credit and overflow pulses
    // --------------------------------------------------
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
            overflow     <= 1'b0;
        end
        else
        begin
            if (wrAccept)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popAccept)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous write and pop leave the count alone
            case ({wrAccept, popAccept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per removed sample
            creditReturn <= popAccept;
            overflow     <= sampleValid & full;
        end
    end

endmodule

//--- clkRst/clkRstGen.sv
// Audio reset and tick generation
module clkRstGen (
    input  logic                          wAudioClk,
    input  logic                          rstN,
    input  logic                          pllLocked,
    input  logic [audioPkg::divWidth-1:0] tickDiv,
    output logic                          audioRstN,
    output logic                          pwmTick
);

    // First stage of the reset synchronizer
    logic lockSync;
    // Tick divider state
    logic [audioPkg::divWidth-1:0] tickCnt;

    // --------------------------------------------------
    // Reset synchronizer
    // --------------------------------------------------
    // Board reset asserts at once
    // Release takes two edges once lock is good
    // Loss of lock pulls the second stage low on the next edge
    always_ff @(posedge wAudioClk or negedge rstN)
    begin
        if (!rstN)
        begin
            lockSync  <= 1'b0;
            audioRstN <= 1'b0;
        end
        else
        begin
            lockSync  <= pllLocked;
            audioRstN <= lockSync & pllLocked;
        end
    end

    // --------------------------------------------------
    // PWM tick divider
    // --------------------------------------------------
    // One tick every tickDiv+1 cycles
    // Held quiet while the audio domain is in reset
    always_ff @(posedge wAudioClk or negedge audioRstN)
    begin
        if (!audioRstN)
        begin
            tickCnt <= '0;
            pwmTick <= 1'b0;
        end
        else if (tickCnt == '0)
        begin
            // Reload picks up divider changes at the boundary
            tickCnt <= tickDiv;
            pwmTick <= 1'b1;
        end
        else
        begin
            tickCnt <= tickCnt - 1'b1;
            pwmTick <= 1'b0;
        end
    end

endmodule

//--- common/audioPkg.sv
// Audio playback shared definitions
package audioPkg;

    // --------------------------------------------------
    // Sample path
    // --------------------------------------------------
    // Mono sample, signed two's complement
    localparam int sampleWidth   = 16;
    // FIFO entries, also the sender's starting credits
    localparam int fifoDepth     = 8;
    localparam int fifoAddrWidth = 3;

    // --------------------------------------------------
    // PWM output
    // --------------------------------------------------
    // 256 ticks per frame
    localparam int dutyWidth = 8;
    // Silence sits at half duty
    localparam logic [dutyWidth-1:0] dutyMid = 8'd128;
    // Arithmetic shift amount, 0 to 7
    localparam int volWidth  = 3;
    localparam int divWidth  = 8;

    // --------------------------------------------------
    // Register port
    // --------------------------------------------------
    localparam int cfgAddrWidth = 2;
    localparam int cfgDataWidth = 8;

    // Bit 0 enable
    localparam logic [cfgAddrWidth-1:0] regCtrl    = 2'd0;
    localparam logic [cfgAddrWidth-1:0] regVolume  = 2'd1;
    localparam logic [cfgAddrWidth-1:0] regTickDiv = 2'd2;
    // Bit 0 overflow, bit 1 underflow, write 1 to clear
    localparam logic [cfgAddrWidth-1:0] regStatus  = 2'd3;

endpackage
